//--- mips_pkg.sv
package mips_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    localparam reg_addr_t REG_LINK    = 5'd31;
    localparam reg_addr_t REG_ZERO    = 5'd0;
    localparam word_t     PC_STEP     = 32'd4;
    localparam word_t     LINK_OFFSET = 32'd8; // return point past the delay slot
    localparam word_t     RESET_PC    = 32'h0000_0000;

    typedef enum logic [5:0] {
        OP_SPECIAL = 6'b000000,
        OP_REGIMM  = 6'b000001,
        OP_J       = 6'b000010,
        OP_JAL     = 6'b000011,
        OP_BEQ     = 6'b000100,
        OP_BNE     = 6'b000101,
        OP_BLEZ    = 6'b000110,
        OP_BGTZ    = 6'b000111,
        OP_ADDI    = 6'b001000,
        OP_ADDIU   = 6'b001001,
        OP_SLTI    = 6'b001010,
        OP_SLTIU   = 6'b001011,
        OP_ANDI    = 6'b001100,
        OP_ORI     = 6'b001101,
        OP_XORI    = 6'b001110,
        OP_LUI     = 6'b001111
    } opcode_e;

    typedef enum logic [5:0] {
        FN_SLL  = 6'b000000,
        FN_SRL  = 6'b000010,
        FN_SRA  = 6'b000011,
        FN_SLLV = 6'b000100,
        FN_SRLV = 6'b000110,
        FN_SRAV = 6'b000111,
        FN_JR   = 6'b001000,
        FN_JALR = 6'b001001,
        FN_ADD  = 6'b100000,
        FN_ADDU = 6'b100001,
        FN_SUB  = 6'b100010,
        FN_SUBU = 6'b100011,
        FN_AND  = 6'b100100,
        FN_OR   = 6'b100101,
        FN_XOR  = 6'b100110,
        FN_NOR  = 6'b100111,
        FN_SLT  = 6'b101010,
        FN_SLTU = 6'b101011
    } funct_e;

    typedef enum logic [4:0] {
        RI_BLTZ = 5'b00000,
        RI_BGEZ = 5'b00001
    } regimm_e;

    typedef enum logic [3:0] {
        ALU_NOP,
        ALU_OR,
        ALU_AND,
        ALU_XOR,
        ALU_NOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_ADD,  // traps on signed overflow
        ALU_ADDU,
        ALU_SUB,  // traps on signed overflow
        ALU_SUBU,
        ALU_SLT,
        ALU_SLTU,
        ALU_LINK  // passes link address
    } alu_op_e;

endpackage

//--- fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage (
    input  logic            clk,
    input  logic            rst_n_i,
    input  mips_pkg::word_t inst_i,
    input  logic            branch_taken_i,
    input  mips_pkg::word_t branch_target_i,
    output mips_pkg::word_t pc_o,
    output mips_pkg::word_t if_pc_o,
    output mips_pkg::word_t if_inst_o
);

    mips_pkg::word_t pc_next;

    // redirect lands after the delay slot has been fetched
    assign pc_next = branch_taken_i ? branch_target_i : pc_o + mips_pkg::PC_STEP;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc_o      <= mips_pkg::RESET_PC;
            if_pc_o   <= mips_pkg::RESET_PC;
            if_inst_o <= '0; // decodes as sll to r0
        end else begin
            pc_o      <= pc_next;
            if_pc_o   <= pc_o;
            if_inst_o <= inst_i;
        end
    end

endmodule

//--- regfile.sv
`timescale 1ns/1ps

module regfile (
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic                we_i,
    input  mips_pkg::reg_addr_t waddr_i,
    input  mips_pkg::word_t     wdata_i,
    input  mips_pkg::reg_addr_t raddr_a_i,
    input  mips_pkg::reg_addr_t raddr_b_i,
    output mips_pkg::word_t     rdata_a_o,
    output mips_pkg::word_t     rdata_b_o
);

    mips_pkg::word_t regs [32];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (waddr_i != mips_pkg::REG_ZERO)) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // no internal bypass, decode forwards from writeback
    assign rdata_a_o = (raddr_a_i == mips_pkg::REG_ZERO) ? '0 : regs[raddr_a_i];
    assign rdata_b_o = (raddr_b_i == mips_pkg::REG_ZERO) ? '0 : regs[raddr_b_i];

endmodule

//--- decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
    input  mips_pkg::word_t     if_pc_i,
    input  mips_pkg::word_t     if_inst_i,
    input  mips_pkg::word_t     rdata_a_i,
    input  mips_pkg::word_t     rdata_b_i,
    input  logic                ex_write_i,
    input  mips_pkg::reg_addr_t ex_dest_i,
    input  mips_pkg::word_t     ex_result_i,
    input  logic                wb_write_i,
    input  mips_pkg::reg_addr_t wb_dest_i,
    input  mips_pkg::word_t     wb_data_i,
    output mips_pkg::reg_addr_t raddr_a_o,
    output mips_pkg::reg_addr_t raddr_b_o,
    output mips_pkg::alu_op_e   alu_op_o,
    output mips_pkg::word_t     operand_a_o,
    output mips_pkg::word_t     operand_b_o,
    output mips_pkg::reg_addr_t dest_addr_o,
    output logic                write_en_o,
    output mips_pkg::word_t     link_addr_o,
    output logic                branch_taken_o,
    output mips_pkg::word_t     branch_target_o
);

    mips_pkg::opcode_e   opcode;
    mips_pkg::funct_e    funct;
    mips_pkg::regimm_e   regimm;
    mips_pkg::reg_addr_t rs;
    mips_pkg::reg_addr_t rt;
    mips_pkg::reg_addr_t rd;
    logic [4:0]          shamt;
    logic [15:0]         imm16;
    mips_pkg::word_t     pc_plus_4;
    mips_pkg::word_t     br_target;
    mips_pkg::word_t     jmp_target;
    mips_pkg::word_t     fwd_a;
    mips_pkg::word_t     fwd_b;
    mips_pkg::word_t     imm_a;
    mips_pkg::word_t     imm_b;
    logic                a_imm;
    logic                b_imm;

    assign opcode = mips_pkg::opcode_e'(if_inst_i[31:26]);
    assign rs     = if_inst_i[25:21];
    assign rt     = if_inst_i[20:16];
    assign rd     = if_inst_i[15:11];
    assign shamt  = if_inst_i[10:6];
    assign funct  = mips_pkg::funct_e'(if_inst_i[5:0]);
    assign regimm = mips_pkg::regimm_e'(rt);
    assign imm16  = if_inst_i[15:0];

    assign pc_plus_4   = if_pc_i + mips_pkg::PC_STEP;
    assign br_target   = pc_plus_4 + {{14{imm16[15]}}, imm16, 2'b00};
    assign jmp_target  = {pc_plus_4[31:28], if_inst_i[25:0], 2'b00}; // same 256MB region
    assign link_addr_o = if_pc_i + mips_pkg::LINK_OFFSET;

    assign raddr_a_o = rs;
    assign raddr_b_o = rt;

    // newest value wins
    always_comb begin
        fwd_a = rdata_a_i;
        if (rs != mips_pkg::REG_ZERO) begin
            if (ex_write_i && (ex_dest_i == rs)) begin
                fwd_a = ex_result_i;
            end else if (wb_write_i && (wb_dest_i == rs)) begin
                fwd_a = wb_data_i;
            end
        end
    end

    always_comb begin
        fwd_b = rdata_b_i;
        if (rt != mips_pkg::REG_ZERO) begin
            if (ex_write_i && (ex_dest_i == rt)) begin
                fwd_b = ex_result_i;
            end else if (wb_write_i && (wb_dest_i == rt)) begin
                fwd_b = wb_data_i;
            end
        end
    end

    always_comb begin
        alu_op_o        = mips_pkg::ALU_NOP;
        dest_addr_o     = rt;
        a_imm           = 1'b0;
        b_imm           = 1'b0;
        imm_a           = {27'b0, shamt};
        imm_b           = {{16{imm16[15]}}, imm16};
        branch_taken_o  = 1'b0;
        branch_target_o = br_target;
        case (opcode)
            mips_pkg::OP_SPECIAL: begin
                dest_addr_o = rd;
                case (funct)
                    mips_pkg::FN_SLL: begin
                        alu_op_o = mips_pkg::ALU_SLL;
                        a_imm    = 1'b1;
                    end
                    mips_pkg::FN_SRL: begin
                        alu_op_o = mips_pkg::ALU_SRL;
                        a_imm    = 1'b1;
                    end
                    mips_pkg::FN_SRA: begin
                        alu_op_o = mips_pkg::ALU_SRA;
                        a_imm    = 1'b1;
                    end
                    mips_pkg::FN_SLLV: alu_op_o = mips_pkg::ALU_SLL;
                    mips_pkg::FN_SRLV: alu_op_o = mips_pkg::ALU_SRL;
                    mips_pkg::FN_SRAV: alu_op_o = mips_pkg::ALU_SRA;
                    mips_pkg::FN_ADD:  alu_op_o = mips_pkg::ALU_ADD;
                    mips_pkg::FN_ADDU: alu_op_o = mips_pkg::ALU_ADDU;
                    mips_pkg::FN_SUB:  alu_op_o = mips_pkg::ALU_SUB;
                    mips_pkg::FN_SUBU: alu_op_o = mips_pkg::ALU_SUBU;
                    mips_pkg::FN_AND:  alu_op_o = mips_pkg::ALU_AND;
                    mips_pkg::FN_OR:   alu_op_o = mips_pkg::ALU_OR;
                    mips_pkg::FN_XOR:  alu_op_o = mips_pkg::ALU_XOR;
                    mips_pkg::FN_NOR:  alu_op_o = mips_pkg::ALU_NOR;
                    mips_pkg::FN_SLT:  alu_op_o = mips_pkg::ALU_SLT;
                    mips_pkg::FN_SLTU: alu_op_o = mips_pkg::ALU_SLTU;
                    mips_pkg::FN_JR: begin
                        branch_taken_o  = 1'b1;
                        branch_target_o = fwd_a;
                    end
                    mips_pkg::FN_JALR: begin
                        alu_op_o        = mips_pkg::ALU_LINK;
                        branch_taken_o  = 1'b1;
                        branch_target_o = fwd_a;
                    end
                    default: ; // unknown funct, no-op
                endcase
            end
            mips_pkg::OP_REGIMM: begin
                case (regimm)
                    mips_pkg::RI_BLTZ: branch_taken_o = fwd_a[31];
                    mips_pkg::RI_BGEZ: branch_taken_o = !fwd_a[31];
                    default: ;
                endcase
            end
            mips_pkg::OP_J: begin
                branch_taken_o  = 1'b1;
                branch_target_o = jmp_target;
            end
            mips_pkg::OP_JAL: begin
                alu_op_o        = mips_pkg::ALU_LINK;
                dest_addr_o     = mips_pkg::REG_LINK;
                branch_taken_o  = 1'b1;
                branch_target_o = jmp_target;
            end
            mips_pkg::OP_BEQ:  branch_taken_o = (fwd_a == fwd_b);
            mips_pkg::OP_BNE:  branch_taken_o = (fwd_a != fwd_b);
            mips_pkg::OP_BLEZ: branch_taken_o = fwd_a[31] || (fwd_a == '0);
            mips_pkg::OP_BGTZ: branch_taken_o = !fwd_a[31] && (fwd_a != '0);
            mips_pkg::OP_ADDI: begin
                alu_op_o = mips_pkg::ALU_ADD;
                b_imm    = 1'b1;
            end
            mips_pkg::OP_ADDIU: begin
                alu_op_o = mips_pkg::ALU_ADDU;
                b_imm    = 1'b1;
            end
            mips_pkg::OP_SLTI: begin
                alu_op_o = mips_pkg::ALU_SLT;
                b_imm    = 1'b1;
            end
            mips_pkg::OP_SLTIU: begin
                alu_op_o = mips_pkg::ALU_SLTU; // sign extended, compared unsigned
                b_imm    = 1'b1;
            end
            mips_pkg::OP_ANDI: begin
                alu_op_o = mips_pkg::ALU_AND;
                b_imm    = 1'b1;
                imm_b    = {16'b0, imm16};
            end
            mips_pkg::OP_ORI: begin
                alu_op_o = mips_pkg::ALU_OR;
                b_imm    = 1'b1;
                imm_b    = {16'b0, imm16};
            end
            mips_pkg::OP_XORI: begin
                alu_op_o = mips_pkg::ALU_XOR;
                b_imm    = 1'b1;
                imm_b    = {16'b0, imm16};
            end
            mips_pkg::OP_LUI: begin
                alu_op_o = mips_pkg::ALU_OR; // zero or upper half
                a_imm    = 1'b1;
                imm_a    = '0;
                b_imm    = 1'b1;
                imm_b    = {imm16, 16'b0};
            end
            default: ;
        endcase
    end

    assign write_en_o  = (alu_op_o != mips_pkg::ALU_NOP);
    assign operand_a_o = a_imm ? imm_a : fwd_a;
    assign operand_b_o = b_imm ? imm_b : fwd_b;

endmodule

//--- execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
    input  logic                clk,
    input  logic                rst_n_i,
    input  mips_pkg::alu_op_e   alu_op_i,
    input  mips_pkg::word_t     operand_a_i,
    input  mips_pkg::word_t     operand_b_i,
    input  mips_pkg::reg_addr_t dest_addr_i,
    input  logic                write_en_i,
    input  mips_pkg::word_t     link_addr_i,
    output logic                ex_write_o,
    output mips_pkg::reg_addr_t ex_dest_o,
    output mips_pkg::word_t     ex_result_o,
    output logic                wb_write_o,
    output mips_pkg::reg_addr_t wb_dest_o,
    output mips_pkg::word_t     wb_data_o
);

    mips_pkg::alu_op_e ex_op;
    logic              ex_we;
    mips_pkg::word_t   ex_a;
    mips_pkg::word_t   ex_b;
    mips_pkg::word_t   ex_link;
    mips_pkg::word_t   sum;
    mips_pkg::word_t   diff;
    logic              ovf;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ex_op <= mips_pkg::ALU_NOP;
            ex_we <= 1'b0;
        end else begin
            ex_op <= alu_op_i;
            ex_we <= write_en_i;
        end
    end

    always_ff @(posedge clk) begin
        ex_a      <= operand_a_i;
        ex_b      <= operand_b_i;
        ex_link   <= link_addr_i;
        ex_dest_o <= dest_addr_i;
    end

    assign sum  = ex_a + ex_b;
    assign diff = ex_a - ex_b;

    always_comb begin
        ovf = 1'b0;
        case (ex_op)
            mips_pkg::ALU_OR:   ex_result_o = ex_a | ex_b;
            mips_pkg::ALU_AND:  ex_result_o = ex_a & ex_b;
            mips_pkg::ALU_XOR:  ex_result_o = ex_a ^ ex_b;
            mips_pkg::ALU_NOR:  ex_result_o = ~(ex_a | ex_b);
            mips_pkg::ALU_SLL:  ex_result_o = ex_b << ex_a[4:0];
            mips_pkg::ALU_SRL:  ex_result_o = ex_b >> ex_a[4:0];
            mips_pkg::ALU_SRA:  ex_result_o = $signed(ex_b) >>> ex_a[4:0];
            mips_pkg::ALU_ADDU: ex_result_o = sum;
            mips_pkg::ALU_SUBU: ex_result_o = diff;
            mips_pkg::ALU_ADD: begin
                ex_result_o = sum;
                ovf         = (ex_a[31] == ex_b[31]) && (sum[31] != ex_a[31]);
            end
            mips_pkg::ALU_SUB: begin
                ex_result_o = diff;
                ovf         = (ex_a[31] != ex_b[31]) && (diff[31] != ex_a[31]);
            end
            mips_pkg::ALU_SLT:  ex_result_o = {31'b0, $signed(ex_a) < $signed(ex_b)};
            mips_pkg::ALU_SLTU: ex_result_o = {31'b0, ex_a < ex_b};
            mips_pkg::ALU_LINK: ex_result_o = ex_link;
            default:            ex_result_o = '0;
        endcase
    end

    // overflow and r0 writes vanish here
    assign ex_write_o = ex_we && !ovf && (ex_dest_o != mips_pkg::REG_ZERO);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wb_write_o <= 1'b0;
        end else begin
            wb_write_o <= ex_write_o;
        end
    end

    always_ff @(posedge clk) begin
        wb_dest_o <= ex_dest_o;
        wb_data_o <= ex_result_o;
    end

endmodule

//--- mips_core.sv
`timescale 1ns/1ps

module mips_core (
    input  logic                clk,
    input  logic                rst_n_i,
    input  mips_pkg::word_t     inst_i,
    output mips_pkg::word_t     pc_o,
    output logic                wb_we_o,
    output mips_pkg::reg_addr_t wb_addr_o,
    output mips_pkg::word_t     wb_data_o
);

    mips_pkg::word_t     if_pc;
    mips_pkg::word_t     if_inst;
    logic                branch_taken;
    mips_pkg::word_t     branch_target;
    mips_pkg::reg_addr_t raddr_a;
    mips_pkg::reg_addr_t raddr_b;
    mips_pkg::word_t     rdata_a;
    mips_pkg::word_t     rdata_b;
    mips_pkg::alu_op_e   alu_op;
    mips_pkg::word_t     operand_a;
    mips_pkg::word_t     operand_b;
    mips_pkg::reg_addr_t dest_addr;
    logic                write_en;
    mips_pkg::word_t     link_addr;
    logic                ex_write;
    mips_pkg::reg_addr_t ex_dest;
    mips_pkg::word_t     ex_result;

    fetch_stage u_fetch (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .inst_i          (inst_i),
        .branch_taken_i  (branch_taken),
        .branch_target_i (branch_target),
        .pc_o            (pc_o),
        .if_pc_o         (if_pc),
        .if_inst_o       (if_inst)
    );

    decode_stage u_decode (
        .if_pc_i         (if_pc),
        .if_inst_i       (if_inst),
        .rdata_a_i       (rdata_a),
        .rdata_b_i       (rdata_b),
        .ex_write_i      (ex_write),
        .ex_dest_i       (ex_dest),
        .ex_result_i     (ex_result),
        .wb_write_i      (wb_we_o),
        .wb_dest_i       (wb_addr_o),
        .wb_data_i       (wb_data_o),
        .raddr_a_o       (raddr_a),
        .raddr_b_o       (raddr_b),
        .alu_op_o        (alu_op),
        .operand_a_o     (operand_a),
        .operand_b_o     (operand_b),
        .dest_addr_o     (dest_addr),
        .write_en_o      (write_en),
        .link_addr_o     (link_addr),
        .branch_taken_o  (branch_taken),
        .branch_target_o (branch_target)
    );

    execute_stage u_execute (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .alu_op_i        (alu_op),
        .operand_a_i     (operand_a),
        .operand_b_i     (operand_b),
        .dest_addr_i     (dest_addr),
        .write_en_i      (write_en),
        .link_addr_i     (link_addr),
        .ex_write_o      (ex_write),
        .ex_dest_o       (ex_dest),
        .ex_result_o     (ex_result),
        .wb_write_o      (wb_we_o),
        .wb_dest_o       (wb_addr_o),
        .wb_data_o       (wb_data_o)
    );

    regfile u_regfile (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .we_i            (wb_we_o),
        .waddr_i         (wb_addr_o),
        .wdata_i         (wb_data_o),
        .raddr_a_i       (raddr_a),
        .raddr_b_i       (raddr_b),
        .rdata_a_o       (rdata_a),
        .rdata_b_o       (rdata_b)
    );

endmodule

//--- tb_mips_core.sv
`timescale 1ns/1ps

module tb_mips_core;

    localparam int CLK_PERIOD = 4;

    logic                clk;
    logic                rst_n_i;
    mips_pkg::word_t     inst_i;
    mips_pkg::word_t     pc_o;
    logic                wb_we_o;
    mips_pkg::reg_addr_t wb_addr_o;
    mips_pkg::word_t     wb_data_o;

    mips_pkg::word_t     prog_q[$];
    string               exp_name_q[$];
    mips_pkg::reg_addr_t exp_addr_q[$];
    mips_pkg::word_t     exp_data_q[$];
    int                  exp_idx = 0;
    int                  mismatch_count = 0;
    int                  fail_count = 0;
    logic                tables_ready = 1'b0;

    mips_core u_dut (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .inst_i    (inst_i),
        .pc_o      (pc_o),
        .wb_we_o   (wb_we_o),
        .wb_addr_o (wb_addr_o),
        .wb_data_o (wb_data_o)
    );

    function automatic mips_pkg::word_t encode_r(input logic [5:0] fn, input int rs,
                                                 input int rt, input int rd, input int sh);
        encode_r = {6'b000000, rs[4:0], rt[4:0], rd[4:0], sh[4:0], fn};
    endfunction

    function automatic mips_pkg::word_t encode_i(input logic [5:0] op, input int rs,
                                                 input int rt, input int imm);
        encode_i = {op, rs[4:0], rt[4:0], imm[15:0]};
    endfunction

    function automatic mips_pkg::word_t encode_j(input logic [5:0] op, input int index);
        encode_j = {op, index[25:0]};
    endfunction

    function automatic int word_index(input mips_pkg::word_t pc);
        word_index = int'(pc / mips_pkg::PC_STEP);
    endfunction

    function automatic mips_pkg::word_t fetch_word(input mips_pkg::word_t pc);
        int idx;
        idx = word_index(pc);
        if (idx < prog_q.size()) begin
            fetch_word = prog_q[idx];
        end else begin
            fetch_word = '0; // past the end reads as a no-op
        end
    endfunction

    task automatic add_expect(input string name, input int addr, input mips_pkg::word_t data);
        exp_name_q.push_back(name);
        exp_addr_q.push_back(mips_pkg::reg_addr_t'(addr));
        exp_data_q.push_back(data);
    endtask

    task automatic check_addr(input string name, input mips_pkg::reg_addr_t expected,
                              input mips_pkg::reg_addr_t actual);
        if (actual !== expected) begin
            $display("mismatch %s addr: expected r%0d, actual r%0d", name, expected, actual);
            mismatch_count++;
        end
    endtask

    task automatic check_data(input string name, input mips_pkg::word_t expected,
                              input mips_pkg::word_t actual);
        if (actual !== expected) begin
            $display("mismatch %s data: expected %h, actual %h", name, expected, actual);
            mismatch_count++;
        end
    endtask

    task automatic load_program();
        prog_q.push_back(encode_i(mips_pkg::OP_LUI, 0, 1, 'h1234));      // 0
        prog_q.push_back(encode_i(mips_pkg::OP_ORI, 1, 1, 'h8765));
        prog_q.push_back(encode_i(mips_pkg::OP_ANDI, 1, 2, 'hF0F0));
        prog_q.push_back(encode_i(mips_pkg::OP_XORI, 1, 3, 'hFFFF));
        prog_q.push_back(encode_i(mips_pkg::OP_ADDIU, 0, 4, 'hFFFE));
        prog_q.push_back(encode_i(mips_pkg::OP_SLTI, 4, 5, 'hFFFF));
        prog_q.push_back(encode_i(mips_pkg::OP_SLTIU, 4, 6, 'hFFFF));
        prog_q.push_back(encode_r(mips_pkg::FN_ADDU, 1, 2, 8, 0));       // 7
        prog_q.push_back(encode_r(mips_pkg::FN_SUBU, 8, 3, 9, 0));
        prog_q.push_back(encode_r(mips_pkg::FN_XOR, 9, 8, 10, 0));
        prog_q.push_back(encode_r(mips_pkg::FN_NOR, 10, 0, 11, 0));
        prog_q.push_back(encode_r(mips_pkg::FN_SLL, 0, 11, 12, 4));
        prog_q.push_back(encode_r(mips_pkg::FN_SRA, 0, 11, 13, 8));
        prog_q.push_back(encode_r(mips_pkg::FN_SRL, 0, 11, 14, 8));
        prog_q.push_back(encode_i(mips_pkg::OP_ADDIU, 0, 15, 3));
        prog_q.push_back(encode_r(mips_pkg::FN_SLLV, 15, 2, 16, 0));
        prog_q.push_back(encode_r(mips_pkg::FN_SRAV, 15, 4, 17, 0));
        prog_q.push_back(encode_r(mips_pkg::FN_SLT, 4, 15, 19, 0));
        prog_q.push_back(encode_r(mips_pkg::FN_SLTU, 4, 15, 20, 0));
        prog_q.push_back(encode_r(mips_pkg::FN_AND, 11, 1, 21, 0));
        prog_q.push_back(encode_r(mips_pkg::FN_ADD, 21, 15, 23, 0));
        prog_q.push_back(encode_r(mips_pkg::FN_SUB, 23, 21, 24, 0));
        prog_q.push_back(encode_i(mips_pkg::OP_LUI, 0, 25, 'h7FFF));     // 22
        prog_q.push_back(encode_i(mips_pkg::OP_ORI, 25, 25, 'hFFFF));
        prog_q.push_back(encode_i(mips_pkg::OP_ADDI, 25, 26, 1));        // overflows
        prog_q.push_back(encode_r(mips_pkg::FN_ADD, 25, 25, 26, 0));     // overflows
        prog_q.push_back(encode_r(mips_pkg::FN_OR, 26, 0, 27, 0));
        prog_q.push_back(encode_i(mips_pkg::OP_ADDIU, 0, 0, 'h55));      // r0 target
        prog_q.push_back(encode_r(mips_pkg::FN_ADDU, 0, 15, 28, 0));
        prog_q.push_back(encode_i(mips_pkg::OP_BEQ, 15, 28, 2));         // 29 taken
        prog_q.push_back(encode_i(mips_pkg::OP_ADDIU, 29, 29, 1));
        prog_q.push_back(encode_i(mips_pkg::OP_ADDIU, 29, 29, 'h100));   // skipped
        prog_q.push_back(encode_i(mips_pkg::OP_BNE, 15, 4, 2));
        prog_q.push_back(encode_i(mips_pkg::OP_ADDIU, 29, 29, 1));
        prog_q.push_back(encode_i(mips_pkg::OP_ADDIU, 29, 29, 'h100));
        prog_q.push_back(encode_i(mips_pkg::OP_BGTZ, 15, 0, 2));
        prog_q.push_back(encode_i(mips_pkg::OP_ADDIU, 29, 29, 1));
        prog_q.push_back(encode_i(mips_pkg::OP_ADDIU, 29, 29, 'h100));
        prog_q.push_back(encode_i(mips_pkg::OP_BLEZ, 4, 0, 2));
        prog_q.push_back(encode_i(mips_pkg::OP_ADDIU, 29, 29, 1));
        prog_q.push_back(encode_i(mips_pkg::OP_ADDIU, 29, 29, 'h100));
        prog_q.push_back(encode_i(mips_pkg::OP_REGIMM, 0, 1, 2));        // bgez r0
        prog_q.push_back(encode_i(mips_pkg::OP_ADDIU, 29, 29, 1));
        prog_q.push_back(encode_i(mips_pkg::OP_ADDIU, 29, 29, 'h100));
        prog_q.push_back(encode_i(mips_pkg::OP_REGIMM, 4, 0, 2));        // bltz r4
        prog_q.push_back(encode_i(mips_pkg::OP_ADDIU, 29, 29, 1));
        prog_q.push_back(encode_i(mips_pkg::OP_ADDIU, 29, 29, 'h100));
        prog_q.push_back(encode_i(mips_pkg::OP_BEQ, 15, 4, 3));          // 47 not taken
        prog_q.push_back(encode_i(mips_pkg::OP_ADDIU, 30, 30, 1));
        prog_q.push_back(encode_i(mips_pkg::OP_BGTZ, 4, 0, 3));
        prog_q.push_back(encode_i(mips_pkg::OP_ADDIU, 30, 30, 1));
        prog_q.push_back(encode_i(mips_pkg::OP_REGIMM, 4, 1, 2));        // bgez r4
        prog_q.push_back(encode_i(mips_pkg::OP_ADDIU, 30, 30, 1));
        prog_q.push_back(encode_j(mips_pkg::OP_J, 56));                  // 53
        prog_q.push_back(encode_i(mips_pkg::OP_ADDIU, 0, 9, 'h201));
        prog_q.push_back(encode_i(mips_pkg::OP_ADDIU, 0, 9, 'h999));     // skipped
        prog_q.push_back(encode_j(mips_pkg::OP_JAL, 61));                // 56
        prog_q.push_back(encode_i(mips_pkg::OP_ADDIU, 0, 10, 'h202));
        prog_q.push_back(encode_i(mips_pkg::OP_ADDIU, 0, 11, 'h203));    // return point
        prog_q.push_back(encode_j(mips_pkg::OP_J, 64));
        prog_q.push_back(encode_i(mips_pkg::OP_ADDIU, 0, 12, 'h204));
        prog_q.push_back(encode_i(mips_pkg::OP_ADDIU, 0, 13, 'h205));    // 61 subroutine
        prog_q.push_back(encode_r(mips_pkg::FN_JR, 31, 0, 0, 0));
        prog_q.push_back(encode_i(mips_pkg::OP_ADDIU, 0, 14, 'h206));
        prog_q.push_back(encode_i(mips_pkg::OP_ADDIU, 0, 16, 'h110));    // 64
        prog_q.push_back(encode_r(mips_pkg::FN_JALR, 16, 0, 17, 0));
        prog_q.push_back(encode_i(mips_pkg::OP_ADDIU, 0, 18, 'h207));
        prog_q.push_back(encode_i(mips_pkg::OP_ADDIU, 0, 18, 'h999));    // skipped
        prog_q.push_back(32'hFC00_0000);                                 // 68 unknown opcode
        prog_q.push_back(encode_r(6'h18, 1, 2, 5, 0));                   // mult, dropped
        prog_q.push_back(encode_i(mips_pkg::OP_ADDIU, 0, 20, 'h209));
        prog_q.push_back(encode_i(mips_pkg::OP_REGIMM, 0, 17, 2));       // bgezal, dropped
        prog_q.push_back(encode_i(mips_pkg::OP_ADDIU, 0, 21, 'h20A));
        prog_q.push_back(encode_r(mips_pkg::FN_OR, 20, 21, 22, 0));
    endtask

    task automatic load_expected();
        add_expect("lui", 1, 32'h1234_0000);
        add_expect("ori", 1, 32'h1234_8765);
        add_expect("andi", 2, 32'h0000_8060);
        add_expect("xori", 3, 32'h1234_789A);
        add_expect("addiu", 4, 32'hFFFF_FFFE);
        add_expect("slti", 5, 32'h0000_0001);
        add_expect("sltiu", 6, 32'h0000_0001);
        add_expect("addu", 8, 32'h1235_07C5);
        add_expect("subu", 9, 32'h0000_8F2B);
        add_expect("xor", 10, 32'h1235_88EE);
        add_expect("nor", 11, 32'hEDCA_7711);
        add_expect("sll", 12, 32'hDCA7_7110);
        add_expect("sra", 13, 32'hFFED_CA77);
        add_expect("srl", 14, 32'h00ED_CA77);
        add_expect("addiu", 15, 32'h0000_0003);
        add_expect("sllv", 16, 32'h0004_0300);
        add_expect("srav", 17, 32'hFFFF_FFFF);
        add_expect("slt", 19, 32'h0000_0001);
        add_expect("sltu", 20, 32'h0000_0000);
        add_expect("and", 21, 32'h0000_0701);
        add_expect("add", 23, 32'h0000_0704);
        add_expect("sub", 24, 32'h0000_0003);
        add_expect("lui_max", 25, 32'h7FFF_0000);
        add_expect("ori_max", 25, 32'h7FFF_FFFF);
        add_expect("after_overflow", 27, 32'h0000_0000);
        add_expect("read_r0", 28, 32'h0000_0003);
        add_expect("beq_slot", 29, 32'h0000_0001);
        add_expect("bne_slot", 29, 32'h0000_0002);
        add_expect("bgtz_slot", 29, 32'h0000_0003);
        add_expect("blez_slot", 29, 32'h0000_0004);
        add_expect("bgez_slot", 29, 32'h0000_0005);
        add_expect("bltz_slot", 29, 32'h0000_0006);
        add_expect("beq_fall", 30, 32'h0000_0001);
        add_expect("bgtz_fall", 30, 32'h0000_0002);
        add_expect("bgez_fall", 30, 32'h0000_0003);
        add_expect("j_slot", 9, 32'h0000_0201);
        add_expect("jal_link", 31, 32'h0000_00E8);
        add_expect("jal_slot", 10, 32'h0000_0202);
        add_expect("subroutine", 13, 32'h0000_0205);
        add_expect("jr_slot", 14, 32'h0000_0206);
        add_expect("return", 11, 32'h0000_0203);
        add_expect("j_back_slot", 12, 32'h0000_0204);
        add_expect("jalr_base", 16, 32'h0000_0110);
        add_expect("jalr_link", 17, 32'h0000_010C);
        add_expect("jalr_slot", 18, 32'h0000_0207);
        add_expect("after_unknown", 20, 32'h0000_0209);
        add_expect("after_regimm", 21, 32'h0000_020A);
        add_expect("last", 22, 32'h0000_020B);
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // instruction memory model
    initial begin
        inst_i = '0;
        forever begin
            @(negedge clk);
            inst_i = fetch_word(pc_o);
        end
    end

    // writeback monitor, sampled mid cycle
    always @(negedge clk) begin
        if (rst_n_i && wb_we_o) begin
            if (exp_idx >= exp_addr_q.size()) begin
                $display("unexpected writeback to r%0d with %h after the expected list ended",
                         wb_addr_o, wb_data_o);
                fail_count++;
            end else begin
                check_addr(exp_name_q[exp_idx], exp_addr_q[exp_idx], wb_addr_o);
                check_data(exp_name_q[exp_idx], exp_data_q[exp_idx], wb_data_o);
                exp_idx++;
            end
        end
    end

    initial begin
        wait (tables_ready);
        #((prog_q.size() + 20) * CLK_PERIOD);
        $display("timeout: the program did not run to its end");
        fail_count++;
        $display("errors: %0d mismatches, %0d other failures", mismatch_count, fail_count);
        $display("Something failed");
        $finish;
    end

    initial begin
        rst_n_i = 1'b0;
        load_program();
        load_expected();
        tables_ready = 1'b1;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n_i = 1'b1;
        // done once fetch runs past the table
        while (word_index(pc_o) < prog_q.size()) begin
            @(negedge clk);
        end
        repeat (4) @(negedge clk); // drain the pipeline
        if (exp_idx < exp_addr_q.size()) begin
            $display("%0d expected writebacks never arrived, first missing is %s",
                     exp_addr_q.size() - exp_idx, exp_name_q[exp_idx]);
            fail_count++;
        end
        $display("errors: %0d mismatches, %0d other failures", mismatch_count, fail_count);
        if (mismatch_count == 0 && fail_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

//--- mips_core.f
mips_pkg.sv
fetch_stage.sv
regfile.sv
decode_stage.sv
execute_stage.sv
mips_core.sv
tb_mips_core.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_mips_core -f mips_core.f
out=$(./obj_dir/Vtb_mips_core)
echo "$out"

if echo "$out" | grep -qx "Everything OK"; then
    exit 0
else
    exit 1
fi
